// ==== async_fifo.sv ====
`timescale 1ns/1ps
`include "stream_cdc_settings.svh"

module async_fifo (
    input  logic                          wr_clk,
    input  logic                          rd_clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  stream_cdc_pkg::fifo_word_t    wr_word,
    input  logic                          rd_en,
    output stream_cdc_pkg::fifo_word_t    rd_word,
    output logic                          full,
    output stream_cdc_pkg::fifo_status_t  status
);
    import stream_cdc_pkg::*;

    localparam int ADDR_W = $clog2(`SCDC_DEPTH);
    // Extra wrap bit separates full from empty
    localparam int PTR_W  = ADDR_W + 1;

    localparam logic [PTR_W-1:0] DEPTH_C = PTR_W'(`SCDC_DEPTH);
    localparam logic [PTR_W-1:0] AE_C    = PTR_W'(`SCDC_AE_THRESH);
    localparam logic [PTR_W-1:0] AF_C    = PTR_W'(`SCDC_AF_THRESH);

    fifo_word_t mem [`SCDC_DEPTH];

    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_nxt;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_nxt;
    logic [PTR_W-1:0] rd_gray;

    // Pointers seen from the other domain
    logic [PTR_W-1:0] wr_bin_rd;
    logic [PTR_W-1:0] rd_bin_wr;

    logic [PTR_W-1:0] wr_count;
    logic [PTR_W-1:0] rd_count;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok      = wr_en && !full;
    assign wr_bin_nxt = wr_bin + PTR_W'(wr_ok);

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_ok) begin
            mem[wr_bin[ADDR_W-1:0]] <= wr_word;
        end
    end

    assign rd_ok      = rd_en && !status.empty;
    assign rd_bin_nxt = rd_bin + PTR_W'(rd_ok);

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_nxt;
            rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
        end
    end

    // Read data lands one cycle after the accepted read
    always_ff @(posedge rd_clk) begin
        if (rd_ok) begin
            rd_word <= mem[rd_bin[ADDR_W-1:0]];
        end
    end

    gray_ptr_sync #(
        .PTR_W (PTR_W)
    ) u_wr_to_rd (
        .clk     (rd_clk),
        .rst_n   (rst_n),
        .gray_in (wr_gray),
        .bin_out (wr_bin_rd)
    );

    gray_ptr_sync #(
        .PTR_W (PTR_W)
    ) u_rd_to_wr (
        .clk     (wr_clk),
        .rst_n   (rst_n),
        .gray_in (rd_gray),
        .bin_out (rd_bin_wr)
    );

    // Modulo subtraction, stale remote pointer keeps flags conservative
    assign wr_count = wr_bin - rd_bin_wr;
    assign rd_count = wr_bin_rd - rd_bin;

    assign full = (wr_count == DEPTH_C);

    always_comb begin
        status.count        = rd_count;
        status.empty        = (rd_count == '0);
        status.almost_empty = (rd_count != '0) && (rd_count <= AE_C);
        status.full         = (rd_count == DEPTH_C);
        status.almost_full  = (rd_count >= AF_C) && (rd_count < DEPTH_C);
    end

endmodule

// ==== channel_accumulator.sv ====
`timescale 1ns/1ps
`include "stream_cdc_settings.svh"

module channel_accumulator (
    input  logic                        rd_clk,
    input  logic                        rst_n,
    input  logic                        drain_en,
    input  logic                        empty,
    output logic                        rd_en,
    input  stream_cdc_pkg::fifo_word_t  rd_word,
    output logic                        acc_valid,
    output stream_cdc_pkg::acc_out_t    acc
);
    import stream_cdc_pkg::*;

    localparam int SUM_W = `SCDC_SUM_W;
    localparam int SEQ_W = `SCDC_SEQ_W;

    acc_state_e state;
    acc_state_e state_nxt;

    logic [SUM_W-1:0] sums [`SCDC_NUM_CHAN];
    logic [SEQ_W-1:0] last_seq;
    logic             seen_any;
    logic [SUM_W-1:0] sum_nxt;
    logic             gap_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ACC_IDLE: begin
                if (drain_en && !empty) begin
                    state_nxt = ACC_FETCH;
                end
            end
            ACC_FETCH: state_nxt = ACC_EMIT;
            ACC_EMIT:  state_nxt = ACC_IDLE;
            default:   state_nxt = ACC_IDLE;
        endcase
    end

    // One word in flight, so reads only start from idle
    assign rd_en     = (state == ACC_IDLE) && drain_en && !empty;
    assign acc_valid = (state == ACC_EMIT);

    // Sum wraps at its own width
    assign sum_nxt = sums[rd_word.chan] + SUM_W'(rd_word.data);
    assign gap_nxt = seen_any && (rd_word.seq != SEQ_W'(last_seq + 1'b1));

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ACC_IDLE;
            last_seq <= '0;
            seen_any <= 1'b0;
            acc      <= '0;
            for (int i = 0; i < `SCDC_NUM_CHAN; i++) begin
                sums[i] <= '0;
            end
        end else begin
            state <= state_nxt;
            // rd_word is valid in the fetch cycle
            if (state == ACC_FETCH) begin
                sums[rd_word.chan] <= sum_nxt;
                last_seq           <= rd_word.seq;
                seen_any           <= 1'b1;
                acc <= acc_out_t'{
                    chan:    rd_word.chan,
                    sum:     sum_nxt,
                    seq_gap: gap_nxt
                };
            end
        end
    end

endmodule

// ==== gray_ptr_sync.sv ====
`timescale 1ns/1ps

module gray_ptr_sync #(
    parameter int PTR_W = 5
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [PTR_W-1:0] gray_in,
    output logic [PTR_W-1:0] bin_out
);

    logic [PTR_W-1:0] meta_q;
    logic [PTR_W-1:0] sync_q;

    // Two flops in the destination domain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= gray_in;
            sync_q <= meta_q;
        end
    end

    // Each binary bit is the XOR of all Gray bits at or above it
    always_comb begin
        for (int i = 0; i < PTR_W; i++) begin
            bin_out[i] = ^(sync_q >> i);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_stream_cdc \
    -f stream_cdc_top.f -o sim_stream_cdc

./obj_dir/sim_stream_cdc > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation finished without failure"

// ==== sample_tagger.sv ====
`timescale 1ns/1ps
`include "stream_cdc_settings.svh"

module sample_tagger (
    input  logic                        wr_clk,
    input  logic                        rst_n,
    input  logic                        sample_stb,
    input  stream_cdc_pkg::sample_in_t  sample,
    input  logic                        full,
    output logic                        wr_en,
    output stream_cdc_pkg::fifo_word_t  wr_word,
    output logic [`SCDC_DROP_W-1:0]     drop_count
);
    import stream_cdc_pkg::*;

    logic [`SCDC_SEQ_W-1:0] seq_cnt;
    logic                   pending;

    // Sequence advances on every strobe, written or not
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_cnt    <= '0;
            pending    <= 1'b0;
            drop_count <= '0;
        end else begin
            pending <= sample_stb;
            if (sample_stb) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
            if (pending && full) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Tagged word held for one cycle
    always_ff @(posedge wr_clk) begin
        if (sample_stb) begin
            wr_word <= fifo_word_t'{
                seq:  seq_cnt,
                chan: sample.chan,
                data: sample.data
            };
        end
    end

    // Full is judged in the cycle the write is presented,
    // so a write issued just before full cannot slip past it
    assign wr_en = pending && !full;

endmodule

// ==== stream_cdc_pkg.sv ====
`include "stream_cdc_settings.svh"

package stream_cdc_pkg;

    typedef struct packed {
        logic [`SCDC_CHAN_W-1:0]   chan;
        logic [`SCDC_SAMPLE_W-1:0] data;
    } sample_in_t;

    // Word as stored in the FIFO, 16 bits
    typedef struct packed {
        logic [`SCDC_SEQ_W-1:0]    seq;
        logic [`SCDC_CHAN_W-1:0]   chan;
        logic [`SCDC_SAMPLE_W-1:0] data;
    } fifo_word_t;

    typedef struct packed {
        logic                          empty;
        logic                          almost_empty;
        logic                          full;
        logic                          almost_full;
        logic [$clog2(`SCDC_DEPTH):0]  count;
    } fifo_status_t;

    typedef struct packed {
        logic [`SCDC_CHAN_W-1:0] chan;
        logic [`SCDC_SUM_W-1:0]  sum;
        logic                    seq_gap;
    } acc_out_t;

    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_FETCH,
        ACC_EMIT
    } acc_state_e;

endpackage

// ==== stream_cdc_props.sv ====
`timescale 1ns/1ps
`include "stream_cdc_settings.svh"

module stream_cdc_props (
    input logic                         rd_clk,
    input logic                         rst_n,
    input logic                         full,
    input logic                         rd_en,
    input logic                         acc_valid,
    input stream_cdc_pkg::fifo_status_t status
);
    import stream_cdc_pkg::*;

    // Writer full and reader empty never overlap
    flags_exclusive: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        !(full && status.empty)
    ) else $error("FIFO full and empty are high together");

    // A write into a full FIFO would push the count past the depth
    no_write_when_full: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        int'(status.count) <= `SCDC_DEPTH
    ) else $error("FIFO holds more words than its depth");

    // Fetch then emit, two cycles after the read
    valid_after_read: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        acc_valid == $past(rd_en, 2)
    ) else $error("acc_valid is not two cycles after rd_en");

endmodule

// Top level carries both the FIFO and consumer nets
bind stream_cdc_top stream_cdc_props u_props (
    .rd_clk    (rd_clk),
    .rst_n     (rst_n),
    .full      (full),
    .rd_en     (rd_en),
    .acc_valid (acc_valid),
    .status    (status)
);

// ==== stream_cdc_settings.svh ====
`ifndef STREAM_CDC_SETTINGS_SVH
`define STREAM_CDC_SETTINGS_SVH

// Payload fields
`define SCDC_SAMPLE_W 8
`define SCDC_CHAN_W 2
`define SCDC_SEQ_W 6

// FIFO geometry, depth must be a power of two
`define SCDC_DEPTH 16
`define SCDC_AE_THRESH 2
`define SCDC_AF_THRESH 14

// Consumer and producer counters
`define SCDC_SUM_W 16
`define SCDC_NUM_CHAN (1 << `SCDC_CHAN_W)
`define SCDC_DROP_W 16

`endif

// ==== stream_cdc_top.f ====
+incdir+.
stream_cdc_pkg.sv
sample_tagger.sv
gray_ptr_sync.sv
async_fifo.sv
channel_accumulator.sv
stream_cdc_top.sv
stream_cdc_props.sv
tb_stream_cdc.sv

// ==== stream_cdc_top.sv ====
`timescale 1ns/1ps
`include "stream_cdc_settings.svh"

module stream_cdc_top (
    input  logic                          wr_clk,
    input  logic                          rd_clk,
    input  logic                          rst_n,
    input  logic                          sample_stb,
    input  stream_cdc_pkg::sample_in_t    sample,
    input  logic                          drain_en,
    output logic                          acc_valid,
    output stream_cdc_pkg::acc_out_t      acc,
    output stream_cdc_pkg::fifo_status_t  status,
    output logic [`SCDC_DROP_W-1:0]       drop_count
);
    import stream_cdc_pkg::*;

    // Write side
    logic       wr_en;
    fifo_word_t wr_word;
    logic       full;

    // Read side
    logic       rd_en;
    fifo_word_t rd_word;

    sample_tagger u_tagger (
        .wr_clk     (wr_clk),
        .rst_n      (rst_n),
        .sample_stb (sample_stb),
        .sample     (sample),
        .full       (full),
        .wr_en      (wr_en),
        .wr_word    (wr_word),
        .drop_count (drop_count)
    );

    async_fifo u_fifo (
        .wr_clk  (wr_clk),
        .rd_clk  (rd_clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_word (wr_word),
        .rd_en   (rd_en),
        .rd_word (rd_word),
        .full    (full),
        .status  (status)
    );

    channel_accumulator u_acc (
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .drain_en  (drain_en),
        .empty     (status.empty),
        .rd_en     (rd_en),
        .rd_word   (rd_word),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

endmodule

// ==== tb_stream_cdc.sv ====
`timescale 1ns/1ps
`include "stream_cdc_settings.svh"

module tb_stream_cdc;
    import stream_cdc_pkg::*;

    localparam int CNT_W = $clog2(`SCDC_DEPTH) + 1;
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(`SCDC_DEPTH);

    typedef struct packed {
        logic [1:0] chan;
        logic [7:0] data;
        logic [7:0] step;
        logic [8:0] reps;
        logic [3:0] gap;
        logic       drain;
    } stim_row_t;

    logic         wr_clk;
    logic         rd_clk;
    logic         rst_n;
    logic         sample_stb;
    sample_in_t   sample;
    logic         drain_en;
    logic         acc_valid;
    acc_out_t     acc;
    fifo_status_t status;
    logic [15:0]  drop_count;

    stim_row_t   rows[$];
    fifo_word_t  exp_q[$];
    logic [15:0] exp_sum [4];
    logic [5:0]  tb_seq;
    logic [5:0]  last_seq;
    logic        seen_any;
    int          value_errs;
    int          other_errs;
    int          cycles;
    int          limit;
    int          sent;
    int          delivered;
    int          gaps_seen;
    int          burst_drops;

    stream_cdc_top i_dut (.*);

    initial begin
        rd_clk = 1'b0;
        forever #4 rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #5.5 wr_clk = ~wr_clk;
    end

    task automatic add_row(input logic [1:0] c, input logic [7:0] d, input logic [7:0] s,
                           input logic [8:0] r, input logic [3:0] g, input logic dr);
        rows.push_back(stim_row_t'{chan: c, data: d, step: s, reps: r, gap: g, drain: dr});
    endtask

    task automatic build_table();
        add_row(2'd0, 8'h11, 8'h00, 9'd1, 4'd4, 1'b1);
        add_row(2'd1, 8'h22, 8'h00, 9'd1, 4'd4, 1'b1);
        add_row(2'd2, 8'h33, 8'h00, 9'd2, 4'd4, 1'b1);
        add_row(2'd3, 8'h44, 8'h00, 9'd1, 4'd4, 1'b1);
        add_row(2'd1, 8'h05, 8'h01, 9'd3, 4'd3, 1'b1);
        // Burst into a stalled consumer
        add_row(2'd0, 8'ha0, 8'h01, 9'd20, 4'd0, 1'b0);
        // Enough large samples to wrap channel 3
        add_row(2'd3, 8'hff, 8'h00, 9'd260, 4'd2, 1'b1);
        add_row(2'd0, 8'h80, 8'h00, 9'd2, 4'd3, 1'b1);
        add_row(2'd1, 8'h90, 8'h00, 9'd2, 4'd3, 1'b1);
        add_row(2'd2, 8'hc0, 8'h00, 9'd2, 4'd3, 1'b1);
        add_row(2'd3, 8'h7f, 8'h00, 9'd2, 4'd3, 1'b1);
        add_row(2'd2, 8'hee, 8'h03, 9'd4, 4'd2, 1'b1);
    endtask

    task automatic apply_row(input stim_row_t row);
        logic [7:0] d;
        d = row.data;
        for (int k = 0; k < int'(row.reps); k++) begin
            @(posedge wr_clk);
            sample_stb <= 1'b1;
            sample     <= sample_in_t'{chan: row.chan, data: d};
            exp_q.push_back(fifo_word_t'{seq: tb_seq, chan: row.chan, data: d});
            tb_seq = tb_seq + 6'd1;
            sent++;
            d = d + row.step;
            if (row.gap != 4'd0) begin
                repeat (int'(row.gap) + int'($urandom % 3)) begin
                    @(posedge wr_clk);
                    sample_stb <= 1'b0;
                end
            end
        end
        @(posedge wr_clk);
        sample_stb <= 1'b0;
    endtask

    task automatic set_drain(input logic v);
        @(posedge rd_clk);
        drain_en <= v;
    endtask

    task automatic wait_drained();
        while (exp_q.size() > 0) begin
            @(negedge rd_clk);
        end
        repeat (4) @(negedge rd_clk);
    endtask

    // First read reaches the writer two to three wr_clk cycles later
    task automatic wait_writer_room();
        while (status.full) begin
            @(negedge rd_clk);
        end
        repeat (3) @(posedge wr_clk);
    endtask

    // Drops are the tail of the burst, so they leave the back of the queue
    task automatic check_burst(input int burst_len);
        int d;
        while (!status.full) begin
            @(negedge rd_clk);
        end
        assert (!status.almost_full && status.count == DEPTH_C) else begin
            value_errs++;
            $display("[FAIL] status.count got %h exp %h, almost_full %h",
                     status.count, DEPTH_C, status.almost_full);
        end
        repeat (6) @(negedge wr_clk);
        d = int'(drop_count) - burst_drops;
        assert (d >= 4 && d == burst_len - `SCDC_DEPTH) else begin
            value_errs++;
            $display("[FAIL] drop_count got %h exp %h", d, burst_len - `SCDC_DEPTH);
        end
        burst_drops = int'(drop_count);
        repeat (d) void'(exp_q.pop_back());
    endtask

    always @(posedge rd_clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout after %0d rd_clk cycles, %0d words still expected",
                     cycles, exp_q.size());
            $display("value errors %0d, other errors %0d", value_errs, other_errs + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    // Flags follow the count shown in the same cycle
    always @(negedge rd_clk) begin
        if (rst_n) begin
            assert (status.empty == (status.count == '0)) else begin
                value_errs++;
                $display("[FAIL] status.empty got %h count %h", status.empty, status.count);
            end
            assert (status.almost_empty == (status.count == 1 || status.count == 2))
            else begin
                value_errs++;
                $display("[FAIL] status.almost_empty got %h count %h",
                         status.almost_empty, status.count);
            end
            assert (status.almost_full == (status.count == 14 || status.count == 15))
            else begin
                value_errs++;
                $display("[FAIL] status.almost_full got %h count %h",
                         status.almost_full, status.count);
            end
        end
    end

    always @(negedge rd_clk) begin
        fifo_word_t w;
        logic       exp_gap;
        if (rst_n && acc_valid) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("acc_valid pulsed with no word outstanding");
            end else begin
                w = exp_q.pop_front();
                exp_gap = seen_any && (w.seq != last_seq + 6'd1);
                exp_sum[w.chan] = exp_sum[w.chan] + 16'(w.data);
                last_seq  = w.seq;
                seen_any  = 1'b1;
                delivered++;
                if (exp_gap) gaps_seen++;
                assert (acc.chan == w.chan) else begin
                    value_errs++;
                    $display("[FAIL] acc.chan got %h exp %h", acc.chan, w.chan);
                end
                assert (acc.sum == exp_sum[w.chan]) else begin
                    value_errs++;
                    $display("[FAIL] acc.sum got %h exp %h", acc.sum, exp_sum[w.chan]);
                end
                assert (acc.seq_gap == exp_gap) else begin
                    value_errs++;
                    $display("[FAIL] acc.seq_gap got %h exp %h", acc.seq_gap, exp_gap);
                end
            end
        end
    end

    initial begin
        int  total;
        logic cur_drain;
        logic burst_open;
        int  burst_len;
        sample_stb = 1'b0;
        sample     = '0;
        drain_en   = 1'b0;
        rst_n      = 1'b0;
        tb_seq     = '0;
        last_seq   = '0;
        seen_any   = 1'b0;
        value_errs = 0;
        other_errs = 0;
        cycles     = 0;
        sent       = 0;
        delivered  = 0;
        gaps_seen  = 0;
        burst_drops = 0;
        cur_drain  = 1'b0;
        burst_open = 1'b0;
        burst_len  = 0;
        total      = 0;
        for (int c = 0; c < 4; c++) exp_sum[c] = '0;
        void'($urandom(32'h1192_f843));
        build_table();
        foreach (rows[r]) total += int'(rows[r].reps);
        limit = total * 40 + 200;

        repeat (3) @(posedge rd_clk);
        rst_n <= 1'b1;
        @(negedge rd_clk);
        assert (status.empty && !status.full && status.count == '0 && !acc_valid) else begin
            value_errs++;
            $display("[FAIL] status after reset got %h acc_valid %h", status, acc_valid);
        end

        foreach (rows[r]) begin
            if (rows[r].drain != cur_drain) begin
                if (!rows[r].drain) begin
                    wait_drained();
                    set_drain(1'b0);
                    burst_open = 1'b1;
                    burst_len  = 0;
                end else begin
                    if (burst_open) check_burst(burst_len);
                    set_drain(1'b1);
                    // Writer still sees full until the first read crosses over
                    if (burst_open) wait_writer_room();
                    burst_open = 1'b0;
                end
                cur_drain = rows[r].drain;
            end
            apply_row(rows[r]);
            if (!cur_drain) burst_len += int'(rows[r].reps);
        end
        wait_drained();

        assert (delivered + int'(drop_count) == sent) else begin
            value_errs++;
            $display("[FAIL] delivered+dropped got %h exp %h",
                     delivered + int'(drop_count), sent);
        end
        assert (gaps_seen == 1) else begin
            other_errs++;
            $display("Expected exactly one sequence gap, model saw %0d", gaps_seen);
        end

        $display("value errors %0d, other errors %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
